// ==== design/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Option status word from the host
`define IO_STATUS_W 32

// Keyboard joystick vector, one bit per mapped key
`define IO_KBJOY_W 10

// Audio sample coming from the core
`define IO_SAMPLE_W 7

// Writers sharing the state bank
`define IO_NUM_PEERS 2

`endif

// ==== design/io_types_pkg.sv ====
`default_nettype none

`include "io_defines.svh"

package io_types_pkg;

	typedef logic [`IO_STATUS_W-1:0] status_t;
	typedef logic [`IO_KBJOY_W-1:0]  kbjoy_t;
	typedef logic [7:0]              joy_t;
	typedef logic [`IO_SAMPLE_W-1:0] sample_t;

	// Word select inside the state bank
	typedef enum logic [1:0] {
		ADDR_STATUS  = 2'd0,
		ADDR_BUTTONS = 2'd1,
		ADDR_JOY0    = 2'd2,
		ADDR_KBJOY   = 2'd3
	} bank_addr_t;

	// Host link frame states
	typedef enum logic [1:0] {IDLE, OPCODE, PAYLOAD, WRITE} link_state_t;

	// PS/2 frame receiver states
	typedef enum logic [1:0] {START, DATA, PARITY, STOP} ps2_state_t;

endpackage

`default_nettype wire

// ==== design/host_cmd_pkg.sv ====
`default_nettype none

package host_cmd_pkg;

	// Host link opcodes, first byte of every frame
	typedef enum logic [7:0] {
		OP_BUTTONS   = 8'h01,
		OP_JOY0      = 8'h02,
		OP_READ_KEYS = 8'h10,
		OP_STATUS    = 8'h1E
	} host_op_t;

	// PS/2 set 2 prefixes
	localparam logic [7:0] SC_EXTEND = 8'hE0;
	localparam logic [7:0] SC_BREAK  = 8'hF0;

	// Arrow keys, only valid after SC_EXTEND
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_UP     = 8'h75;

	localparam logic [7:0] SC_SPACE  = 8'h29;
	localparam logic [7:0] SC_KEY1   = 8'h16;
	localparam logic [7:0] SC_KEY2   = 8'h1E;
	localparam logic [7:0] SC_KEY5   = 8'h2E;
	localparam logic [7:0] SC_ENTER  = 8'h5A;
	localparam logic [7:0] SC_ESC    = 8'h76;

endpackage

`default_nettype wire

// ==== design/state_bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One writer's path into the state bank, four-phase req/ack
interface state_bus_if import io_types_pkg::*; ();

	logic       req;
	logic       ack;
	bank_addr_t addr;
	// Narrow words sit in the low bits
	status_t    wdata;

	modport peer (
		output req,
		output addr,
		output wdata,
		input  ack
	);

	modport arb (
		input  req,
		input  addr,
		input  wdata,
		output ack
	);

endinterface

`default_nettype wire

// ==== design/spi_host_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module spi_host_link import io_types_pkg::*, host_cmd_pkg::*; (
	input  wire         clk_sys,
	input  wire         reset,
	input  wire         spi_sck,
	input  wire         spi_ss,
	input  wire         spi_di,
	input  wire kbjoy_t kbjoy,
	output logic        spi_do,
	state_bus_if.peer   bus
);

	// [1] is the synchronized level, [2] the previous one for edge detect
	logic [2:0]  sck_sync;
	logic [1:0]  ss_sync;
	logic [1:0]  di_sync;
	logic        sck_rise;
	logic        sck_fall;
	logic        ss_high;

	link_state_t state;
	logic [2:0]  bit_cnt;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_byte;
	logic        byte_done;
	logic [1:0]  bytes_left;
	bank_addr_t  wr_addr;
	status_t     payload;
	logic [7:0]  tx_shift;
	logic        req_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sck_sync <= 3'b000;
			ss_sync  <= 2'b11;
			di_sync  <= 2'b00;
		end else begin
			sck_sync <= {sck_sync[1:0], spi_sck};
			ss_sync  <= {ss_sync[0], spi_ss};
			di_sync  <= {di_sync[0], spi_di};
		end
	end

	assign sck_rise  = sck_sync[1] & ~sck_sync[2];
	assign sck_fall  = ~sck_sync[1] & sck_sync[2];
	assign ss_high   = ss_sync[1];
	assign rx_byte   = {rx_shift[6:0], di_sync[1]};
	assign byte_done = sck_rise & ~ss_high & (bit_cnt == 3'd7);

	// MSB first on rising SCK
	always_ff @(posedge clk_sys) begin
		if (sck_rise && !ss_high)
			rx_shift <= rx_byte;
	end

	// Payload bytes arrive LSB first for the status word
	always_ff @(posedge clk_sys) begin
		if (state == PAYLOAD && byte_done) begin
			if (wr_addr == ADDR_STATUS)
				payload <= {rx_byte, payload[$bits(status_t)-1:8]};
			else
				payload <= status_t'(rx_byte);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= IDLE;
			bit_cnt    <= 3'd0;
			bytes_left <= 2'd0;
			wr_addr    <= ADDR_STATUS;
			req_q      <= 1'b0;
			tx_shift   <= 8'h00;
			spi_do     <= 1'b0;
		end else begin
			if (ss_high)
				bit_cnt <= 3'd0;
			else if (sck_rise)
				bit_cnt <= bit_cnt + 3'd1;

			// Reply shifts out on falling SCK, zeros once it is spent
			if (ss_high) begin
				tx_shift <= 8'h00;
				spi_do   <= 1'b0;
			end else if (sck_fall) begin
				spi_do   <= tx_shift[7];
				tx_shift <= {tx_shift[6:0], 1'b0};
			end

			if (req_q && bus.ack)
				req_q <= 1'b0;

			case (state)
				IDLE: begin
					if (!ss_high)
						state <= OPCODE;
				end
				OPCODE: begin
					if (ss_high) begin
						state <= IDLE;
					end else if (byte_done) begin
						case (rx_byte)
							OP_STATUS: begin
								wr_addr    <= ADDR_STATUS;
								bytes_left <= 2'd3;
								state      <= PAYLOAD;
							end
							OP_BUTTONS: begin
								wr_addr    <= ADDR_BUTTONS;
								bytes_left <= 2'd0;
								state      <= PAYLOAD;
							end
							OP_JOY0: begin
								wr_addr    <= ADDR_JOY0;
								bytes_left <= 2'd0;
								state      <= PAYLOAD;
							end
							OP_READ_KEYS: tx_shift <= kbjoy[7:0];
							// unknown opcodes are dropped
							default: ;
						endcase
					end
				end
				PAYLOAD: begin
					if (ss_high) begin
						state <= IDLE;
					end else if (byte_done) begin
						if (bytes_left == 2'd0) begin
							req_q <= 1'b1;
							state <= WRITE;
						end else begin
							bytes_left <= bytes_left - 2'd1;
						end
					end
				end
				WRITE: begin
					// Full handshake finishes even if SS already went high
					if (!req_q && !bus.ack)
						state <= ss_high ? IDLE : OPCODE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bus.req   = req_q;
	assign bus.addr  = wr_addr;
	assign bus.wdata = payload;

	// The SCK rate limit must retire every bank write before the next byte
	a_write_retired: assert property (@(posedge clk_sys) disable iff (reset)
		byte_done |-> !req_q)
		else $error("SPI byte completed while a bank write was still pending");

endmodule

`default_nettype wire

// ==== design/ps2_joy_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_joy_decoder import io_types_pkg::*, host_cmd_pkg::*; (
	input  wire       clk_sys,
	input  wire       reset,
	input  wire       ps2_clk,
	input  wire       ps2_data,
	state_bus_if.peer bus
);

	logic [2:0] clk_sync;
	logic [1:0] data_sync;
	logic       ps2_fall;

	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       parity_ok;
	logic       frame_valid;
	logic [7:0] code;

	logic       ext_seen;
	logic       brk_seen;
	logic       key_hit;
	logic [3:0] key_idx;
	kbjoy_t     keys;
	kbjoy_t     next_keys;
	logic       key_change;
	logic       dirty;
	logic       bus_idle;
	logic       launch;
	logic       req_q;
	status_t    wdata_q;

	// Both lines idle high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clk_sync  <= 3'b111;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	assign ps2_fall = ~clk_sync[1] & clk_sync[2];

	// Frame: start 0, 8 data bits LSB first, odd parity, stop 1
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= START;
			bit_cnt     <= 3'd0;
			parity_ok   <= 1'b0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (ps2_fall) begin
				case (state)
					START: begin
						bit_cnt <= 3'd0;
						if (!data_sync[1])
							state <= DATA;
					end
					DATA: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= PARITY;
					end
					PARITY: begin
						parity_ok <= ^{shift, data_sync[1]};
						state     <= STOP;
					end
					STOP: begin
						frame_valid <= data_sync[1] & parity_ok;
						state       <= START;
					end
					default: state <= START;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ps2_fall && state == DATA)
			shift <= {data_sync[1], shift[7:1]};
		if (ps2_fall && state == STOP)
			code <= shift;
	end

	// Key map, arrows need the E0 prefix
	always_comb begin
		key_hit = 1'b1;
		key_idx = 4'd0;
		if (ext_seen) begin
			case (code)
				SC_RIGHT: key_idx = 4'd0;
				SC_LEFT:  key_idx = 4'd1;
				SC_DOWN:  key_idx = 4'd2;
				SC_UP:    key_idx = 4'd3;
				default:  key_hit = 1'b0;
			endcase
		end else begin
			case (code)
				SC_SPACE: key_idx = 4'd4;
				SC_KEY1:  key_idx = 4'd5;
				SC_KEY2:  key_idx = 4'd6;
				SC_KEY5:  key_idx = 4'd7;
				SC_ENTER: key_idx = 4'd8;
				SC_ESC:   key_idx = 4'd9;
				default:  key_hit = 1'b0;
			endcase
		end

		next_keys = keys;
		if (frame_valid && key_hit)
			next_keys[key_idx] = ~brk_seen;
	end

	assign key_change = frame_valid & (next_keys != keys);
	assign bus_idle   = ~req_q & ~bus.ack;
	// A change seen mid-handshake goes out once the bus is free
	assign launch     = bus_idle & (key_change | dirty);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ext_seen <= 1'b0;
			brk_seen <= 1'b0;
			keys     <= '0;
			dirty    <= 1'b0;
			req_q    <= 1'b0;
		end else begin
			if (frame_valid) begin
				if (code == SC_EXTEND) begin
					ext_seen <= 1'b1;
				end else if (code == SC_BREAK) begin
					brk_seen <= 1'b1;
				end else begin
					ext_seen <= 1'b0;
					brk_seen <= 1'b0;
				end
			end
			keys <= next_keys;

			if (launch)
				dirty <= 1'b0;
			else if (key_change)
				dirty <= 1'b1;

			if (req_q && bus.ack)
				req_q <= 1'b0;
			else if (launch)
				req_q <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (launch)
			wdata_q <= status_t'(next_keys);
	end

	assign bus.req   = req_q;
	assign bus.addr  = ADDR_KBJOY;
	assign bus.wdata = wdata_q;

endmodule

`default_nettype wire

// ==== design/state_bank_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module state_bank_arbiter import io_types_pkg::*; (
	input  wire        clk_sys,
	input  wire        reset,
	state_bus_if.arb   spi_bus,
	state_bus_if.arb   kbd_bus,
	output status_t    status,
	output logic [1:0] buttons,
	output logic [1:0] switches,
	output joy_t       joystick_0,
	output kbjoy_t     kbjoy,
	output logic       core_reset
);

	// Bit 0 is the SPI link, bit 1 the keyboard
	logic [`IO_NUM_PEERS-1:0] req_v;
	logic [`IO_NUM_PEERS-1:0] ack_q;
	logic [`IO_NUM_PEERS-1:0] grant;
	// Set when the keyboard wins a tie next time
	logic                     prio_kbd;

	logic                     wr_en;
	bank_addr_t               wr_addr;
	status_t                  wr_data;

	assign req_v = {kbd_bus.req, spi_bus.req};

	// New grant only once the previous ack has dropped
	always_comb begin
		grant = '0;
		if (ack_q == '0) begin
			if (req_v[0] && (!req_v[1] || !prio_kbd))
				grant[0] = 1'b1;
			else if (req_v[1])
				grant[1] = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ack_q    <= '0;
			prio_kbd <= 1'b0;
		end else begin
			ack_q <= grant | (ack_q & req_v);
			if (grant[0])
				prio_kbd <= 1'b1;
			else if (grant[1])
				prio_kbd <= 1'b0;
		end
	end

	assign spi_bus.ack = ack_q[0];
	assign kbd_bus.ack = ack_q[1];

	// Write lands in the single cycle where req and ack are both high
	assign wr_en   = |(ack_q & req_v);
	assign wr_addr = ack_q[1] ? kbd_bus.addr : spi_bus.addr;
	assign wr_data = ack_q[1] ? kbd_bus.wdata : spi_bus.wdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status     <= '0;
			buttons    <= 2'b00;
			switches   <= 2'b00;
			joystick_0 <= '0;
			kbjoy      <= '0;
		end else if (wr_en) begin
			case (wr_addr)
				ADDR_STATUS:  status <= wr_data;
				ADDR_BUTTONS: begin
					buttons  <= wr_data[1:0];
					switches <= wr_data[3:2];
				end
				ADDR_JOY0:    joystick_0 <= wr_data[$bits(joy_t)-1:0];
				ADDR_KBJOY:   kbjoy <= wr_data[$bits(kbjoy_t)-1:0];
				default: ;
			endcase
		end
	end

	// Core held in reset by the reset option, menu reset or button 1
	always_ff @(posedge clk_sys) begin
		if (reset)
			core_reset <= 1'b1;
		else
			core_reset <= status[0] | status[6] | buttons[1];
	end

	for (genvar i = 0; i < `IO_NUM_PEERS; i++) begin : g_ack_chk
		a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (reset)
			$rose(ack_q[i]) |-> req_v[i])
			else $error("ack raised on port %0d without a pending req", i);

		// A peer starts its next write only after the previous ack is gone
		a_req_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
			$rose(req_v[i]) |-> !ack_q[i])
			else $error("req raised on port %0d while its ack was still high", i);
	end

endmodule

`default_nettype wire

// ==== design/sigma_delta_dac.sv ====
`timescale 1ns/10ps
`default_nettype none

module sigma_delta_dac import io_types_pkg::*; (
	input  wire          clk_sys,
	input  wire          reset,
	input  wire sample_t sample,
	output logic         dac_out
);

	// Residue of the accumulator, carry is not stored
	sample_t                 acc_q;
	logic [$bits(sample_t):0] acc_sum;

	assign acc_sum = {1'b0, acc_q} + {1'b0, sample};

	// Carry out is the pulse density output
	assign dac_out = acc_sum[$bits(sample_t)];

	always_ff @(posedge clk_sys) begin
		if (reset)
			acc_q <= '0;
		else
			acc_q <= acc_sum[$bits(sample_t)-1:0];
	end

endmodule

`default_nettype wire

// ==== design/io_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module io_core_top import io_types_pkg::*; (
	input  wire             clk_sys,
	input  wire             reset,
	input  wire             spi_sck,
	input  wire             spi_ss,
	input  wire             spi_di,
	input  wire             ps2_clk,
	input  wire             ps2_data,
	input  wire sample_t    audio_in,
	output wire             spi_do,
	output wire             audio_out,
	output wire status_t    status,
	output wire logic [1:0] buttons,
	output wire logic [1:0] switches,
	output wire joy_t       joystick_0,
	output wire kbjoy_t     kbjoy,
	output wire             core_reset
);

	state_bus_if spi_bus ();
	state_bus_if kbd_bus ();

	spi_host_link i_spi_link (
		.clk_sys (clk_sys),
		.reset   (reset),
		.spi_sck (spi_sck),
		.spi_ss  (spi_ss),
		.spi_di  (spi_di),
		.kbjoy   (kbjoy),
		.spi_do  (spi_do),
		.bus     (spi_bus)
	);

	ps2_joy_decoder i_keyboard (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.bus      (kbd_bus)
	);

	state_bank_arbiter i_bank (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.spi_bus    (spi_bus),
		.kbd_bus    (kbd_bus),
		.status     (status),
		.buttons    (buttons),
		.switches   (switches),
		.joystick_0 (joystick_0),
		.kbjoy      (kbjoy),
		.core_reset (core_reset)
	);

	sigma_delta_dac i_dac (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sample  (audio_in),
		.dac_out (audio_out)
	);

endmodule

`default_nettype wire

// ==== tb/tb_io_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module tb_io_core import io_types_pkg::*, host_cmd_pkg::*; ();

	typedef enum logic [1:0] {K_SPI, K_KEY, K_BOTH, K_AUDIO} stim_kind_t;

	// One stimulus step, codes are right-aligned with the first code highest
	typedef struct packed {
		stim_kind_t  kind;
		logic [7:0]  op;
		logic [23:0] codes;
		logic [1:0]  ncodes;
		logic [31:0] payload;
		logic        use_lcg;
		logic        bad_parity;
		logic [31:0] exp_val;
	} stim_t;

	logic        clk_sys;
	logic        reset;
	logic        spi_sck;
	logic        spi_ss;
	logic        spi_di;
	logic        ps2_clk;
	logic        ps2_data;
	sample_t     audio_in;
	wire         spi_do;
	wire         audio_out;
	status_t     status;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	joy_t        joystick_0;
	kbjoy_t      kbjoy;
	logic        core_reset;

	stim_t       stim_q[$];
	logic [31:0] lcg_state;
	int          value_errors;
	int          timeout_errors;

	// Expected bank contents
	status_t     exp_status;
	logic [1:0]  exp_buttons;
	logic [1:0]  exp_switches;
	joy_t        exp_joy0;
	kbjoy_t      exp_kbjoy;

	io_core_top i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.spi_sck    (spi_sck),
		.spi_ss     (spi_ss),
		.spi_di     (spi_di),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.audio_in   (audio_in),
		.spi_do     (spi_do),
		.audio_out  (audio_out),
		.status     (status),
		.buttons    (buttons),
		.switches   (switches),
		.joystick_0 (joystick_0),
		.kbjoy      (kbjoy),
		.core_reset (core_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic stim_t host_entry(logic [7:0] op, logic [31:0] payload, logic use_lcg);
		stim_t e;
		e = '0;
		e.kind    = K_SPI;
		e.op      = op;
		e.payload = payload;
		e.use_lcg = use_lcg;
		return e;
	endfunction

	function automatic stim_t key_entry(logic [23:0] codes, logic [1:0] n, logic bad,
		logic [31:0] kb);
		stim_t e;
		e = '0;
		e.kind       = K_KEY;
		e.codes      = codes;
		e.ncodes     = n;
		e.bad_parity = bad;
		e.exp_val    = kb;
		return e;
	endfunction

	function automatic stim_t audio_entry(logic [31:0] s);
		stim_t e;
		e = '0;
		e.kind    = K_AUDIO;
		e.exp_val = s;
		return e;
	endfunction

	// Core reset rule: reset option, menu reset or button 1
	function automatic logic core_reset_rule();
		return exp_status[0] | exp_status[6] | exp_buttons[1];
	endfunction

	function automatic logic outputs_match();
		return status === exp_status && buttons === exp_buttons && switches === exp_switches
			&& joystick_0 === exp_joy0 && kbjoy === exp_kbjoy
			&& core_reset === core_reset_rule();
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_outputs();
		check_value("status", status, exp_status);
		check_value("buttons", buttons, exp_buttons);
		check_value("switches", switches, exp_switches);
		check_value("joystick_0", joystick_0, exp_joy0);
		check_value("kbjoy", kbjoy, exp_kbjoy);
		check_value("core_reset", core_reset, core_reset_rule());
	endtask

	task automatic wait_match(input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!outputs_match() && n < 500) begin
			@(negedge clk_sys);
			n++;
		end
		if (!outputs_match()) begin
			$display("Timeout: bank outputs did not settle within 500 cycles after %s", what);
			timeout_errors++;
		end
		check_outputs();
	endtask

	// Mode 0, SCK at clk_sys/10, entered and left on a rising clk edge
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		int i;
		for (i = 7; i >= 0; i--) begin
			spi_di <= tx[i];
			repeat (5) @(posedge clk_sys);
			rx[i] = spi_do;
			spi_sck <= 1'b1;
			repeat (5) @(posedge clk_sys);
			spi_sck <= 1'b0;
		end
	endtask

	task automatic spi_frame(input logic [7:0] op, input logic [31:0] data, input int nbytes,
		output logic [7:0] reply);
		logic [7:0] rx;
		int i;
		@(posedge clk_sys);
		spi_ss  <= 1'b0;
		spi_sck <= 1'b0;
		repeat (5) @(posedge clk_sys);
		spi_byte(op, rx);
		for (i = 0; i < nbytes; i++)
			spi_byte(data[8*i +: 8], rx);
		reply = rx;
		repeat (10) @(posedge clk_sys);
		spi_ss <= 1'b1;
		spi_di <= 1'b0;
	endtask

	// Start, data LSB first, odd parity, stop; data changes while PS/2 clock is high
	task automatic ps2_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		int i;
		bits = {1'b1, ~^code ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2_data <= bits[i];
			repeat (40) @(posedge clk_sys);
			ps2_clk <= 1'b0;
			repeat (40) @(posedge clk_sys);
			ps2_clk <= 1'b1;
		end
	endtask

	task automatic send_keys(input stim_t e);
		int i;
		for (i = 0; i < e.ncodes; i++) begin
			@(posedge clk_sys);
			ps2_frame(e.codes[8*(e.ncodes-1-i) +: 8], e.bad_parity && i == e.ncodes - 1);
			repeat (20) @(posedge clk_sys);
		end
		exp_kbjoy = e.exp_val[`IO_KBJOY_W-1:0];
	endtask

	task automatic send_host(input stim_t e);
		logic [31:0] data;
		logic [7:0]  reply;
		data = e.use_lcg ? lcg_next() : e.payload;
		case (e.op)
			OP_STATUS: begin
				spi_frame(e.op, data, 4, reply);
				exp_status = data;
			end
			OP_BUTTONS: begin
				spi_frame(e.op, data, 1, reply);
				exp_buttons  = data[1:0];
				exp_switches = data[3:2];
			end
			OP_JOY0: begin
				spi_frame(e.op, data, 1, reply);
				exp_joy0 = data[7:0];
			end
			default: begin
				// Key readback, MSB first in the byte after the opcode
				spi_frame(e.op, 32'h0, 1, reply);
				check_value("READ_KEYS reply", reply, exp_kbjoy[7:0]);
			end
		endcase
	endtask

	task automatic clear_model();
		exp_status   = '0;
		exp_buttons  = 2'b00;
		exp_switches = 2'b00;
		exp_joy0     = '0;
		exp_kbjoy    = '0;
	endtask

	task automatic audio_density(input stim_t e);
		int ones;
		@(posedge clk_sys);
		reset    <= 1'b1;
		audio_in <= e.exp_val[`IO_SAMPLE_W-1:0];
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		ones = 0;
		repeat (128) begin
			@(negedge clk_sys);
			ones += audio_out;
		end
		check_value("audio ones in 128 cycles", ones, e.exp_val);
		clear_model();
		check_outputs();
	endtask

	task automatic build_stimulus();
		stim_q.push_back(host_entry(OP_STATUS, 32'h0, 1'b1));
		stim_q.push_back(host_entry(OP_BUTTONS, 32'h0D, 1'b0));
		stim_q.push_back(host_entry(OP_JOY0, 32'h0, 1'b1));
		// Core reset sources, each set and cleared
		stim_q.push_back(host_entry(OP_STATUS, 32'h0, 1'b0));
		stim_q.push_back(host_entry(OP_STATUS, 32'h1, 1'b0));
		stim_q.push_back(host_entry(OP_STATUS, 32'h0, 1'b0));
		stim_q.push_back(host_entry(OP_STATUS, 32'h40, 1'b0));
		stim_q.push_back(host_entry(OP_STATUS, 32'h0, 1'b0));
		stim_q.push_back(host_entry(OP_BUTTONS, 32'h2, 1'b0));
		stim_q.push_back(host_entry(OP_BUTTONS, 32'h0, 1'b0));
		// Keyboard make and break
		stim_q.push_back(key_entry({8'h00, SC_EXTEND, SC_RIGHT}, 2'd2, 1'b0, 32'h001));
		stim_q.push_back(key_entry({16'h0, SC_SPACE}, 2'd1, 1'b0, 32'h011));
		stim_q.push_back(key_entry({16'h0, SC_KEY1}, 2'd1, 1'b1, 32'h011));
		stim_q.push_back(key_entry({SC_EXTEND, SC_BREAK, SC_RIGHT}, 2'd3, 1'b0, 32'h010));
		stim_q.push_back(key_entry({16'h0, SC_KEY5}, 2'd1, 1'b0, 32'h090));
		stim_q.push_back(key_entry({16'h0, SC_ENTER}, 2'd1, 1'b0, 32'h190));
		stim_q.push_back(key_entry({8'h00, SC_BREAK, SC_SPACE}, 2'd2, 1'b0, 32'h180));
		stim_q.push_back(key_entry({8'h00, SC_EXTEND, SC_UP}, 2'd2, 1'b0, 32'h188));
		// Escape and a joystick write landing together
		stim_q.push_back(key_entry({16'h0, SC_ESC}, 2'd1, 1'b0, 32'h388));
		stim_q[$].kind    = K_BOTH;
		stim_q[$].op      = OP_JOY0;
		stim_q[$].use_lcg = 1'b1;
		stim_q.push_back(host_entry(OP_READ_KEYS, 32'h0, 1'b0));
		stim_q.push_back(audio_entry(0));
		stim_q.push_back(audio_entry(1));
		stim_q.push_back(audio_entry(37));
		stim_q.push_back(audio_entry(64));
		stim_q.push_back(audio_entry(127));
	endtask

	initial begin
		reset          = 1'b1;
		spi_sck        = 1'b0;
		spi_ss         = 1'b1;
		spi_di         = 1'b0;
		ps2_clk        = 1'b1;
		ps2_data       = 1'b1;
		audio_in       = '0;
		lcg_state      = 32'd16383;
		value_errors   = 0;
		timeout_errors = 0;
		clear_model();
		build_stimulus();

		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("core_reset during reset", core_reset, 1'b1);
		@(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(negedge clk_sys);
		check_outputs();
		check_value("spi_do", spi_do, 1'b0);
		check_value("audio_out", audio_out, 1'b0);

		foreach (stim_q[i]) begin
			case (stim_q[i].kind)
				K_SPI: begin
					send_host(stim_q[i]);
					if (stim_q[i].op != OP_READ_KEYS)
						wait_match("an SPI frame");
				end
				K_KEY: begin
					send_keys(stim_q[i]);
					wait_match("a PS/2 key sequence");
				end
				K_BOTH: begin
					// SPI frame delayed so both writes retire at about the same time
					fork
						send_keys(stim_q[i]);
						begin
							repeat (680) @(posedge clk_sys);
							send_host(stim_q[i]);
						end
					join
					wait_match("concurrent PS/2 and SPI writes");
				end
				default: audio_density(stim_q[i]);
			endcase
		end

		$display("Summary: %0d value errors, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/io_types_pkg.sv
design/host_cmd_pkg.sv
design/state_bus_if.sv
design/spi_host_link.sv
design/ps2_joy_decoder.sv
design/state_bank_arbiter.sv
design/sigma_delta_dac.sv
design/io_core_top.sv
tb/tb_io_core.sv
